//--- common/sb_pkg.sv
`default_nettype none

package sb_pkg;

    // store buffer geometry
    localparam int SB_SIZE  = 4;
    localparam int SB_PTR_W = 2;
    // counters must hold the value SB_SIZE itself
    localparam int CNT_W    = SB_PTR_W + 1;

    // bus widths
    localparam int ADDR_W  = 32;
    localparam int DATA_W  = 32;
    localparam int STRB_W  = DATA_W / 8;
    // word address, byte offset dropped
    localparam int WADDR_W = ADDR_W - 2;

    // store access size as decoded from funct3
    typedef enum logic [1:0] {
        SIZE_B = 2'b00,
        SIZE_H = 2'b01,
        SIZE_W = 2'b10
    } size_e;

    // one buffer entry, 68 bits
    typedef struct packed {
        logic [WADDR_W-1:0] addr;
        logic [DATA_W-1:0]  data;
        logic [STRB_W-1:0]  strb;
        logic               valid;
        logic               commit;
    } sb_entry_t;

endpackage

`default_nettype wire

//--- source/store_align.sv
`timescale 1ns/100ps
`default_nettype none

module store_align (
    input  logic                      clk,
    input  logic                      rst_n,
    // store request from execute
    input  logic                      st_valid_i,
    input  logic [sb_pkg::ADDR_W-1:0] st_addr_i,
    input  logic [sb_pkg::DATA_W-1:0] st_data_i,
    input  sb_pkg::size_e             st_size_i,
    output logic                      st_ready_o,
    // aligned entry toward the store buffer
    output logic                      in_valid_o,
    input  logic                      in_ready_i,
    output sb_pkg::sb_entry_t         entry_o,
    output logic                      misalign_o
);

    logic [1:0]                offset;
    logic [sb_pkg::STRB_W-1:0] strb;
    logic [sb_pkg::DATA_W-1:0] lane_mask;
    logic [sb_pkg::DATA_W-1:0] lane_data;
    logic                      misaligned;
    logic                      accept;

    assign offset = st_addr_i[1:0];

    // strobes and alignment check per size
    always_comb begin
        strb       = '0;
        misaligned = 1'b0;
        case (st_size_i)
            sb_pkg::SIZE_B: begin
                strb = 4'b0001 << offset;
            end
            sb_pkg::SIZE_H: begin
                strb       = 4'b0011 << offset;
                misaligned = offset[0];
            end
            sb_pkg::SIZE_W: begin
                strb       = 4'b1111;
                misaligned = (offset != 2'b00);
            end
            default: begin
                // unused encoding, never buffered
                misaligned = 1'b1;
            end
        endcase
    end

    // byte lanes outside the strobe are zeroed
    always_comb begin
        for (int b = 0; b < sb_pkg::STRB_W; b++) begin
            lane_mask[8*b +: 8] = {8{strb[b]}};
        end
    end

    assign lane_data = (st_data_i << {offset, 3'b000}) & lane_mask;

    assign entry_o.addr   = st_addr_i[sb_pkg::ADDR_W-1:2];
    assign entry_o.data   = lane_data;
    assign entry_o.strb   = strb;
    assign entry_o.valid  = 1'b1;
    assign entry_o.commit = 1'b0;

    // misaligned stores are taken from the core but never pushed
    assign in_valid_o = st_valid_i & ~misaligned;
    assign st_ready_o = in_ready_i;
    assign accept     = st_valid_i & in_ready_i;

    // one pulse per dropped store
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            misalign_o <= 1'b0;
        end else begin
            misalign_o <= accept & misaligned;
        end
    end

endmodule

`default_nettype wire

//--- storebuffer/storebuffer.sv
`timescale 1ns/100ps
`default_nettype none

module storebuffer (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              flush_i,
    input  logic              commit_i,
    // push side
    input  logic              in_valid_i,
    input  sb_pkg::sb_entry_t in_entry_i,
    output logic              in_ready_o,
    // drain side
    output logic              drain_valid_o,
    input  logic              drain_ready_i,
    output sb_pkg::sb_entry_t drain_entry_o
);

    // payload storage
    sb_pkg::sb_entry_t mem_q [sb_pkg::SB_SIZE];

    // per entry state bits
    logic [sb_pkg::SB_SIZE-1:0] vld_q;
    logic [sb_pkg::SB_SIZE-1:0] cbit_q;

    // head for push, cptr for next commit, tail for pop
    logic [sb_pkg::SB_PTR_W-1:0] head_q;
    logic [sb_pkg::SB_PTR_W-1:0] cptr_q;
    logic [sb_pkg::SB_PTR_W-1:0] tail_q;
    logic [sb_pkg::SB_PTR_W-1:0] tail_d;

    logic [sb_pkg::CNT_W-1:0] cnt_q;
    logic [sb_pkg::CNT_W-1:0] cnt_d;
    logic [sb_pkg::CNT_W-1:0] ccnt_q;
    logic [sb_pkg::CNT_W-1:0] ccnt_d;

    logic ready_q;
    logic push;
    logic pop;
    logic do_commit;

    logic [sb_pkg::SB_SIZE-1:0] push_oh;
    logic [sb_pkg::SB_SIZE-1:0] cmt_oh;
    logic [sb_pkg::SB_SIZE-1:0] pop_oh;

    assign in_ready_o = ready_q;

    assign push = in_valid_i & ready_q & ~flush_i;
    assign pop  = drain_valid_o & drain_ready_i;

    // commit only a valid entry that is still speculative; flush wins
    assign do_commit = commit_i & ~flush_i & vld_q[cptr_q] & ~cbit_q[cptr_q];

    always_comb begin
        push_oh          = '0;
        cmt_oh           = '0;
        pop_oh           = '0;
        push_oh[head_q]  = push;
        cmt_oh[cptr_q]   = do_commit;
        pop_oh[tail_q]   = pop;
    end

    always_comb begin
        tail_d = tail_q + sb_pkg::SB_PTR_W'(pop);
        ccnt_d = ccnt_q + sb_pkg::CNT_W'(do_commit) - sb_pkg::CNT_W'(pop);
        if (flush_i) begin
            // only committed entries remain
            cnt_d = ccnt_d;
        end else begin
            cnt_d = cnt_q + sb_pkg::CNT_W'(push) - sb_pkg::CNT_W'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            head_q  <= '0;
            cptr_q  <= '0;
            tail_q  <= '0;
            cnt_q   <= '0;
            ccnt_q  <= '0;
            ready_q <= 1'b0;
        end else begin
            tail_q  <= tail_d;
            cnt_q   <= cnt_d;
            ccnt_q  <= ccnt_d;
            cptr_q  <= cptr_q + sb_pkg::SB_PTR_W'(do_commit);
            ready_q <= (cnt_d < sb_pkg::SB_SIZE);
            if (flush_i) begin
                // rewind head to just past the last committed entry
                head_q <= tail_d + ccnt_d[sb_pkg::SB_PTR_W-1:0];
            end else begin
                head_q <= head_q + sb_pkg::SB_PTR_W'(push);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            vld_q  <= '0;
            cbit_q <= '0;
        end else if (flush_i) begin
            // committed entries survive, the popping one still leaves
            vld_q  <= vld_q & cbit_q & ~pop_oh;
            cbit_q <= cbit_q & ~pop_oh;
        end else begin
            vld_q  <= (vld_q & ~pop_oh) | push_oh;
            cbit_q <= (cbit_q & ~pop_oh & ~push_oh) | cmt_oh;
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem_q[head_q] <= in_entry_i;
        end
    end

    // tail entry goes out once committed
    assign drain_valid_o = vld_q[tail_q] & cbit_q[tail_q];

    always_comb begin
        drain_entry_o        = mem_q[tail_q];
        drain_entry_o.valid  = vld_q[tail_q];
        drain_entry_o.commit = cbit_q[tail_q];
    end

endmodule

`default_nettype wire

//--- source/wb_store_master.sv
`timescale 1ns/100ps
`default_nettype none

module wb_store_master (
    input  logic                      clk,
    input  logic                      rst_n,
    // committed entries from the store buffer
    input  logic                      drain_valid_i,
    input  sb_pkg::sb_entry_t         drain_entry_i,
    output logic                      drain_ready_o,
    // wishbone classic master
    output logic                      wb_cyc_o,
    output logic                      wb_stb_o,
    output logic                      wb_we_o,
    output logic [sb_pkg::ADDR_W-1:0] wb_adr_o,
    output logic [sb_pkg::DATA_W-1:0] wb_dat_o,
    output logic [sb_pkg::STRB_W-1:0] wb_sel_o,
    input  logic                      wb_ack_i
);

    typedef enum logic {
        S_IDLE,
        S_BUSY
    } state_e;

    state_e state_q;
    logic   pop;
    logic   busy;

    logic [sb_pkg::ADDR_W-1:0] adr_q;
    logic [sb_pkg::DATA_W-1:0] dat_q;
    logic [sb_pkg::STRB_W-1:0] sel_q;

    // accept a new entry only between bus cycles
    assign drain_ready_o = (state_q == S_IDLE);
    assign pop           = drain_valid_i & drain_ready_o;
    assign busy          = (state_q == S_BUSY);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= S_IDLE;
        end else begin
            case (state_q)
                S_IDLE: begin
                    if (pop) begin
                        state_q <= S_BUSY;
                    end
                end
                S_BUSY: begin
                    // single write ends on the first ack
                    if (wb_ack_i) begin
                        state_q <= S_IDLE;
                    end
                end
                default: begin
                    state_q <= S_IDLE;
                end
            endcase
        end
    end

    // held stable for the whole bus cycle
    always_ff @(posedge clk) begin
        if (pop) begin
            adr_q <= {drain_entry_i.addr, 2'b00};
            dat_q <= drain_entry_i.data;
            sel_q <= drain_entry_i.strb;
        end
    end

    // write only master, cyc and stb move together
    assign wb_cyc_o = busy;
    assign wb_stb_o = busy;
    assign wb_we_o  = busy;
    assign wb_adr_o = adr_q;
    assign wb_dat_o = dat_q;
    assign wb_sel_o = sel_q;

endmodule

`default_nettype wire

//--- source/store_path_top.sv
`timescale 1ns/100ps
`default_nettype none

module store_path_top (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      flush_i,
    input  logic                      commit_i,
    // store input from execute
    input  logic                      st_valid_i,
    input  logic [sb_pkg::ADDR_W-1:0] st_addr_i,
    input  logic [sb_pkg::DATA_W-1:0] st_data_i,
    input  sb_pkg::size_e             st_size_i,
    output logic                      st_ready_o,
    output logic                      misalign_o,
    // data memory port
    output logic                      wb_cyc_o,
    output logic                      wb_stb_o,
    output logic                      wb_we_o,
    output logic [sb_pkg::ADDR_W-1:0] wb_adr_o,
    output logic [sb_pkg::DATA_W-1:0] wb_dat_o,
    output logic [sb_pkg::STRB_W-1:0] wb_sel_o,
    input  logic                      wb_ack_i
);

    // align to buffer
    logic              in_valid;
    logic              in_ready;
    sb_pkg::sb_entry_t in_entry;

    // buffer to bus master
    logic              drain_valid;
    logic              drain_ready;
    sb_pkg::sb_entry_t drain_entry;

    store_align align0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .st_valid_i (st_valid_i),
        .st_addr_i  (st_addr_i),
        .st_data_i  (st_data_i),
        .st_size_i  (st_size_i),
        .st_ready_o (st_ready_o),
        .in_valid_o (in_valid),
        .in_ready_i (in_ready),
        .entry_o    (in_entry),
        .misalign_o (misalign_o)
    );

    storebuffer sb0 (
        .clk           (clk),
        .rst_n         (rst_n),
        .flush_i       (flush_i),
        .commit_i      (commit_i),
        .in_valid_i    (in_valid),
        .in_entry_i    (in_entry),
        .in_ready_o    (in_ready),
        .drain_valid_o (drain_valid),
        .drain_ready_i (drain_ready),
        .drain_entry_o (drain_entry)
    );

    wb_store_master wbm0 (
        .clk           (clk),
        .rst_n         (rst_n),
        .drain_valid_i (drain_valid),
        .drain_entry_i (drain_entry),
        .drain_ready_o (drain_ready),
        .wb_cyc_o      (wb_cyc_o),
        .wb_stb_o      (wb_stb_o),
        .wb_we_o       (wb_we_o),
        .wb_adr_o      (wb_adr_o),
        .wb_dat_o      (wb_dat_o),
        .wb_sel_o      (wb_sel_o),
        .wb_ack_i      (wb_ack_i)
    );

endmodule

`default_nettype wire

//--- verification/store_path_chk.sv
`timescale 1ns/100ps
`default_nettype none

module store_path_chk (
    input logic                        clk,
    input logic                        rst_n,
    input logic                        push_i,
    input logic [sb_pkg::SB_SIZE-1:0]  vld_i,
    input logic [sb_pkg::SB_PTR_W-1:0] head_i,
    input logic [sb_pkg::CNT_W-1:0]    cnt_i,
    input logic                        cyc_i,
    input logic                        stb_i,
    input logic                        ack_i,
    input logic [sb_pkg::ADDR_W-1:0]   adr_i,
    input logic [sb_pkg::DATA_W-1:0]   dat_i,
    input logic [sb_pkg::STRB_W-1:0]   sel_i
);

    // buffer occupancy
    no_push_when_full: assert property (@(posedge clk) disable iff (!rst_n)
        push_i |-> !vld_i[head_i])
        else $error("push into an occupied store buffer entry");

    count_in_range: assert property (@(posedge clk) disable iff (!rst_n)
        cnt_i <= sb_pkg::CNT_W'(sb_pkg::SB_SIZE))
        else $error("store buffer count above its size");

    // wishbone classic, request held until ack
    bus_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (stb_i && !ack_i) |=> (stb_i && $stable(adr_i) && $stable(dat_i) && $stable(sel_i)))
        else $error("wishbone request changed before ack");

    cycle_ends_after_ack: assert property (@(posedge clk) disable iff (!rst_n)
        (stb_i && ack_i) |=> !cyc_i)
        else $error("wishbone cycle still open after ack");

endmodule

bind store_path_top store_path_chk chk0 (
    .clk    (clk),
    .rst_n  (rst_n),
    .push_i (sb0.push),
    .vld_i  (sb0.vld_q),
    .head_i (sb0.head_q),
    .cnt_i  (sb0.cnt_q),
    .cyc_i  (wb_cyc_o),
    .stb_i  (wb_stb_o),
    .ack_i  (wb_ack_i),
    .adr_i  (wb_adr_o),
    .dat_i  (wb_dat_o),
    .sel_i  (wb_sel_o)
);

`default_nettype wire

//--- verification/store_path_monitor.sv
`timescale 1ns/100ps
`default_nettype none

module store_path_monitor (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         st_valid_i,
    input  logic [31:0]  st_addr_i,
    input  logic         st_ready_i,
    input  logic [31:0]  exp_dat_i,
    input  logic [3:0]   exp_sel_i,
    input  logic         commit_i,
    input  logic         flush_i,
    input  logic         misalign_i,
    input  logic         full_chk_i,
    input  logic         done_i,
    input  logic [127:0] name_i,
    input  logic         wb_cyc_i,
    input  logic         wb_stb_i,
    input  logic         wb_we_i,
    input  logic         wb_ack_i,
    input  logic [31:0]  wb_adr_i,
    input  logic [31:0]  wb_dat_i,
    input  logic [3:0]   wb_sel_i,
    output int           err_cnt_o,
    output int           pending_o
);

    // speculative stores, then committed writes awaiting the bus
    logic [31:0]  spec_adr[$];
    logic [31:0]  spec_dat[$];
    logic [3:0]   spec_sel[$];
    logic [127:0] spec_name[$];
    logic [31:0]  exp_adr[$];
    logic [31:0]  exp_dat[$];
    logic [3:0]   exp_sel[$];
    logic [127:0] exp_name[$];
    logic         mis_exp;
    logic [127:0] mis_name;
    int           errors;

    initial begin
        errors  = 0;
        mis_exp = 1'b0;
    end

    assign err_cnt_o = errors;

    always @(posedge clk) begin
        if (!rst_n) begin
            spec_adr.delete();
            spec_dat.delete();
            spec_sel.delete();
            spec_name.delete();
            mis_exp = 1'b0;
        end else begin
            if (misalign_i !== mis_exp) begin
                $display("FAIL %0s misalign_o expected %0b actual %0b",
                         mis_exp ? mis_name : name_i, mis_exp, misalign_i);
                errors++;
            end
            mis_exp = 1'b0;
            if (full_chk_i && st_ready_i !== 1'b0) begin
                $display("FAIL %0s st_ready_o expected 0 actual %0b", name_i, st_ready_i);
                errors++;
            end
            if (wb_cyc_i && wb_stb_i && wb_ack_i) begin
                if (exp_adr.size() == 0) begin
                    $display("ERROR: bus write to %h while no committed store was pending",
                             wb_adr_i);
                    errors++;
                end else begin
                    if (wb_we_i !== 1'b1) begin
                        $display("FAIL %0s we expected 1 actual %0b", exp_name[0], wb_we_i);
                        errors++;
                    end
                    if (wb_adr_i !== exp_adr[0]) begin
                        $display("FAIL %0s adr expected %h actual %h", exp_name[0],
                                 exp_adr[0], wb_adr_i);
                        errors++;
                    end
                    if (wb_dat_i !== exp_dat[0]) begin
                        $display("FAIL %0s dat expected %h actual %h", exp_name[0],
                                 exp_dat[0], wb_dat_i);
                        errors++;
                    end
                    if (wb_sel_i !== exp_sel[0]) begin
                        $display("FAIL %0s sel expected %h actual %h", exp_name[0],
                                 exp_sel[0], wb_sel_i);
                        errors++;
                    end
                    void'(exp_adr.pop_front());
                    void'(exp_dat.pop_front());
                    void'(exp_sel.pop_front());
                    void'(exp_name.pop_front());
                end
            end
            // flush drops every speculative store
            if (flush_i) begin
                spec_adr.delete();
                spec_dat.delete();
                spec_sel.delete();
                spec_name.delete();
            end else if (commit_i && spec_adr.size() > 0) begin
                exp_adr.push_back(spec_adr.pop_front());
                exp_dat.push_back(spec_dat.pop_front());
                exp_sel.push_back(spec_sel.pop_front());
                exp_name.push_back(spec_name.pop_front());
            end
            if (st_valid_i && st_ready_i) begin
                if (exp_sel_i == 4'b0000) begin
                    // no lanes expected, store must be rejected
                    mis_exp  = 1'b1;
                    mis_name = name_i;
                end else if (!flush_i) begin
                    spec_adr.push_back({st_addr_i[31:2], 2'b00});
                    spec_dat.push_back(exp_dat_i);
                    spec_sel.push_back(exp_sel_i);
                    spec_name.push_back(name_i);
                end
            end
            if (done_i && exp_adr.size() > 0) begin
                $display("ERROR: %0d committed stores never appeared on the bus",
                         exp_adr.size());
                errors++;
            end
        end
        pending_o = exp_adr.size();
    end

endmodule

`default_nettype wire

//--- verification/store_path_tb.sv
`timescale 1ns/100ps
`default_nettype none

module store_path_tb;

    localparam int MAX_ROWS = 128;
    localparam logic [2:0] OP_IDLE  = 3'd0;
    localparam logic [2:0] OP_ST    = 3'd1;
    localparam logic [2:0] OP_CM    = 3'd2;
    localparam logic [2:0] OP_FL    = 3'd3;
    localparam logic [2:0] OP_HOLD  = 3'd4;
    localparam logic [2:0] OP_FREE  = 3'd5;
    localparam logic [2:0] OP_FULL  = 3'd6;
    localparam logic [2:0] OP_DRAIN = 3'd7;

    logic          clk;
    logic          rst_n;
    logic          flush;
    logic          commit;
    logic          st_valid;
    logic [31:0]   st_addr;
    logic [31:0]   st_data;
    sb_pkg::size_e st_size;
    logic          st_ready;
    logic          misalign;
    logic          wb_cyc;
    logic          wb_stb;
    logic          wb_we;
    logic [31:0]   wb_adr;
    logic [31:0]   wb_dat;
    logic [3:0]    wb_sel;
    logic          wb_ack;
    logic          full_chk;
    logic          done;
    logic          ack_block;
    logic          block_q;
    logic [127:0]  cur_name;
    logic [31:0]   exp_dat;
    logic [3:0]    exp_sel;
    int            err_cnt;
    int            pending;

    // stimulus table with expected lanes, zero strobes mark a rejected store
    logic [2:0]    op_t   [MAX_ROWS];
    logic [31:0]   adr_t  [MAX_ROWS];
    logic [31:0]   dat_t  [MAX_ROWS];
    logic [1:0]    size_t [MAX_ROWS];
    logic [31:0]   edat_t [MAX_ROWS];
    logic [3:0]    esel_t [MAX_ROWS];
    logic [127:0]  name_t [MAX_ROWS];
    int            n_rows;
    int            seed;
    int            delay;
    int            cycles;
    int            limit;

    store_path_top dut0 (
        .clk(clk), .rst_n(rst_n), .flush_i(flush), .commit_i(commit),
        .st_valid_i(st_valid), .st_addr_i(st_addr), .st_data_i(st_data),
        .st_size_i(st_size), .st_ready_o(st_ready), .misalign_o(misalign),
        .wb_cyc_o(wb_cyc), .wb_stb_o(wb_stb), .wb_we_o(wb_we), .wb_adr_o(wb_adr),
        .wb_dat_o(wb_dat), .wb_sel_o(wb_sel), .wb_ack_i(wb_ack)
    );

    store_path_monitor mon0 (
        .clk(clk), .rst_n(rst_n), .st_valid_i(st_valid), .st_addr_i(st_addr),
        .st_ready_i(st_ready), .exp_dat_i(exp_dat), .exp_sel_i(exp_sel),
        .commit_i(commit), .flush_i(flush), .misalign_i(misalign),
        .full_chk_i(full_chk), .done_i(done), .name_i(cur_name),
        .wb_cyc_i(wb_cyc), .wb_stb_i(wb_stb), .wb_we_i(wb_we), .wb_ack_i(wb_ack),
        .wb_adr_i(wb_adr), .wb_dat_i(wb_dat), .wb_sel_i(wb_sel),
        .err_cnt_o(err_cnt), .pending_o(pending)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic add_row(input logic [2:0] op, input logic [31:0] a, input logic [31:0] d,
                           input logic [1:0] s, input logic [127:0] nm);
        op_t[n_rows]   = op;
        adr_t[n_rows]  = a;
        dat_t[n_rows]  = d;
        size_t[n_rows] = s;
        name_t[n_rows] = nm;
        n_rows++;
    endtask

    task automatic add_store(input logic [31:0] a, input logic [31:0] d, input logic [1:0] s,
                             input logic [31:0] ed, input logic [3:0] es,
                             input logic [127:0] nm);
        edat_t[n_rows] = ed;
        esel_t[n_rows] = es;
        add_row(OP_ST, a, d, s, nm);
    endtask

    task automatic store_commit(input logic [31:0] a, input logic [31:0] d,
                                input logic [1:0] s, input logic [31:0] ed,
                                input logic [3:0] es, input logic [127:0] nm);
        add_store(a, d, s, ed, es, nm);
        add_row(OP_CM, 0, 0, 0, nm);
    endtask

    // byte i of the source lands in lane off + i
    task automatic expected_lanes(input logic [31:0] d, input logic [1:0] s,
                                  input logic [1:0] off, output logic [31:0] ed,
                                  output logic [3:0] es);
        int nbytes;
        nbytes = (s == 2'b00) ? 1 : (s == 2'b01) ? 2 : 4;
        ed = '0;
        es = '0;
        for (int i = 0; i < nbytes; i++) begin
            es[off + i]            = 1'b1;
            ed[8 * (off + i) +: 8] = d[8 * i +: 8];
        end
    endtask

    task automatic build_table();
        logic [31:0] r;
        logic [1:0]  s;
        logic [1:0]  off;
        logic [31:0] d;
        logic [31:0] ed;
        logic [3:0]  es;
        n_rows = 0;
        store_commit(32'h1000, 32'h11223344, 2'b00, 32'h00000044, 4'b0001, "byte_off0");
        store_commit(32'h1001, 32'h55667788, 2'b00, 32'h00008800, 4'b0010, "byte_off1");
        store_commit(32'h1002, 32'h99aabbcc, 2'b00, 32'h00cc0000, 4'b0100, "byte_off2");
        store_commit(32'h1003, 32'hddeeff01, 2'b00, 32'h01000000, 4'b1000, "byte_off3");
        store_commit(32'h1010, 32'hcafe1234, 2'b01, 32'h00001234, 4'b0011, "half_off0");
        store_commit(32'h1012, 32'hbeef5678, 2'b01, 32'h56780000, 4'b1100, "half_off2");
        store_commit(32'h1020, 32'hdeadbeef, 2'b10, 32'hdeadbeef, 4'b1111, "word_off0");
        // program order, the last store is flushed
        add_store(32'h1100, 32'h00000001, 2'b10, 32'h00000001, 4'b1111, "order_a");
        add_store(32'h1104, 32'h00000002, 2'b10, 32'h00000002, 4'b1111, "order_b");
        add_row(OP_CM, 0, 0, 0, "order_a");
        add_row(OP_CM, 0, 0, 0, "order_b");
        add_store(32'h1108, 32'h00000003, 2'b10, 32'h00000003, 4'b1111, "order_spec");
        add_row(OP_FL, 0, 0, 0, "order_flush");
        add_row(OP_DRAIN, 0, 0, 0, "order_drain");
        // flush with two committed and two speculative entries
        add_row(OP_HOLD, 0, 0, 0, "flush_hold");
        for (int k = 0; k < 4; k++) begin
            add_store(32'h1200 + 4 * k, 32'ha0000000 + k, 2'b10,
                      32'ha0000000 + k, 4'b1111, "flush_st");
        end
        add_row(OP_CM, 0, 0, 0, "flush_cm0");
        add_row(OP_CM, 0, 0, 0, "flush_cm1");
        add_row(OP_FL, 0, 0, 0, "flush_fl");
        add_row(OP_FREE, 0, 0, 0, "flush_free");
        store_commit(32'h1210, 32'h0badf00d, 2'b10, 32'h0badf00d, 4'b1111, "flush_after");
        add_row(OP_DRAIN, 0, 0, 0, "flush_drain");
        // back-pressure, five stores
        add_row(OP_HOLD, 0, 0, 0, "full_hold");
        for (int k = 0; k < 4; k++) begin
            add_store(32'h1300 + 4 * k, 32'hb0000000 + k, 2'b10,
                      32'hb0000000 + k, 4'b1111, "full_st");
        end
        add_row(OP_FULL, 0, 0, 0, "full_ready");
        add_row(OP_CM, 0, 0, 0, "full_cm");
        add_row(OP_FREE, 0, 0, 0, "full_free");
        add_store(32'h1310, 32'hb0000004, 2'b10, 32'hb0000004, 4'b1111, "full_st5");
        for (int k = 0; k < 4; k++) begin
            add_row(OP_CM, 0, 0, 0, "full_cm");
        end
        add_row(OP_DRAIN, 0, 0, 0, "full_drain");
        // misaligned stores never reach the bus
        add_store(32'h1401, 32'h12345678, 2'b01, 32'h0, 4'b0000, "mis_half");
        add_store(32'h1402, 32'h9abcdef0, 2'b10, 32'h0, 4'b0000, "mis_word");
        add_row(OP_CM, 0, 0, 0, "mis_cm0");
        add_row(OP_CM, 0, 0, 0, "mis_cm1");
        add_row(OP_DRAIN, 0, 0, 0, "mis_drain");
        // random legal stores under random ack delays
        for (int k = 0; k < 12; k++) begin
            r = $random(seed);
            case (r[1:0])
                2'b00:   s = 2'b00;
                2'b01:   s = 2'b01;
                default: s = 2'b10;
            endcase
            off = (s == 2'b00) ? r[3:2] : (s == 2'b01) ? {r[3], 1'b0} : 2'b00;
            d = $random(seed);
            expected_lanes(d, s, off, ed, es);
            add_store({18'h0, 4'h3, r[11:4], off}, d, s, ed, es, "rand_st");
            if (k % 2 == 1) begin
                add_row(OP_CM, 0, 0, 0, "rand_cm");
                add_row(OP_CM, 0, 0, 0, "rand_cm");
            end
        end
        add_row(OP_IDLE, 0, 0, 0, "idle");
    endtask

    task automatic clear_inputs();
        st_valid = 1'b0;
        commit   = 1'b0;
        flush    = 1'b0;
        full_chk = 1'b0;
    endtask

    task automatic wait_drain();
        @(negedge clk);
        clear_inputs();
        while (pending != 0 || wb_cyc) begin
            @(negedge clk);
        end
    endtask

    task automatic apply_row(input int i);
        @(negedge clk);
        clear_inputs();
        cur_name = name_t[i];
        case (op_t[i])
            OP_ST: begin
                st_valid = 1'b1;
                st_addr  = adr_t[i];
                st_data  = dat_t[i];
                st_size  = sb_pkg::size_e'(size_t[i]);
                exp_dat  = edat_t[i];
                exp_sel  = esel_t[i];
                while (!st_ready) begin
                    @(negedge clk);
                end
            end
            OP_CM:    commit = 1'b1;
            OP_FL:    flush = 1'b1;
            OP_HOLD:  ack_block = 1'b1;
            OP_FREE:  ack_block = 1'b0;
            OP_FULL:  full_chk = 1'b1;
            OP_DRAIN: wait_drain();
            default: begin
            end
        endcase
    endtask

    // memory responder, ack after 0 to 3 wait cycles
    always @(posedge clk) begin
        block_q <= ack_block;
    end

    always @(negedge clk) begin
        if (!rst_n) begin
            wb_ack = 1'b0;
            delay  = -1;
        end else if (wb_ack) begin
            wb_ack = 1'b0;
        end else if (wb_cyc && !block_q) begin
            if (delay < 0) begin
                delay = {$random(seed)} % 4;
            end
            if (delay == 0) begin
                wb_ack = 1'b1;
                delay  = -1;
            end else begin
                delay = delay - 1;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > limit) begin
            $display("timeout after %0d cycles, the DUT stopped making progress", cycles);
            $display("tests failed");
            $finish;
        end
    end

    initial begin
        seed      = 3319;
        cycles    = 0;
        limit     = 100000;
        rst_n     = 1'b0;
        st_addr   = '0;
        st_data   = '0;
        st_size   = sb_pkg::SIZE_W;
        exp_dat   = '0;
        exp_sel   = '0;
        wb_ack    = 1'b0;
        ack_block = 1'b0;
        block_q   = 1'b0;
        done      = 1'b0;
        delay     = -1;
        cur_name  = "reset";
        clear_inputs();
        build_table();
        limit = n_rows * 12 + 10;
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        for (int i = 0; i < n_rows; i++) begin
            apply_row(i);
        end
        wait_drain();
        done = 1'b1;
        @(negedge clk);
        done = 1'b0;
        @(negedge clk);
        $display("errors: %0d", err_cnt);
        if (err_cnt == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
common/sb_pkg.sv
source/store_align.sv
storebuffer/storebuffer.sv
source/wb_store_master.sv
source/store_path_top.sv
verification/store_path_chk.sv
verification/store_path_monitor.sv
verification/store_path_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the store path testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing -Wno-fatal \
    --top-module store_path_tb -f verilog.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vstore_path_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "all tests passed"; then
    exit 0
fi
exit 1
